//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_emesh_mem -f emesh_mem_top.f -o sim_tb

run: compile
	@out=$$(./obj_dir/sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

//--- dv/emesh_testdata.txt
// port write datamode ctrlmode dstaddr data srcaddr exp_data exp_srcaddr
// datamode 0 byte 1 short 2 word 3 double, expected columns are zero for writes
0 1 2 00 00000010 12345678 00000000 00000000 00000000
1 1 2 00 00000018 9abcdef0 00000000 00000000 00000000
0 0 2 00 00000010 00000000 0a0b0c00 12345678 00000000
1 0 2 00 00000018 00000000 1a1b1c10 9abcdef0 00000000
0 1 3 00 00000020 33221100 77665544 00000000 00000000
1 1 0 00 00000021 000000aa 00000000 00000000 00000000
0 1 1 00 00000026 0000beef 00000000 00000000 00000000
0 1 0 00 00000024 0000005c 00000000 00000000 00000000
1 0 2 00 00000020 00000000 2a2b2c20 3322aa00 00000000
0 0 2 05 00000024 00000000 3a3b3c30 beef555c 00000000
1 0 3 00 00000020 00000000 4a4b4c40 3322aa00 beef555c
1 0 0 00 00000021 00000000 4a4b4c41 000000aa 00000000
0 0 1 00 00000026 00000000 5a5b5c50 0000beef 00000000
0 0 1 00 00000022 00000000 5a5b5c52 00003322 00000000
1 1 3 00 00000040 cafef00d deadbeef 00000000 00000000
1 0 3 00 00000040 00000000 6a6b6c60 cafef00d deadbeef
0 0 3 1f 00000040 00000000 7a7b7c70 cafef00d deadbeef
0 0 2 00 00000044 00000000 7a7b7c74 deadbeef 00000000
1 0 1 00 00000046 00000000 8a8b8c86 0000dead 00000000
1 0 0 00 00000013 00000000 8a8b8c93 00000012 00000000

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic nreset
);

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset let go on a rising edge
   initial
   begin
      nreset <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      nreset <= 1'b1;
   end

endmodule

//--- dv/tb_emesh_mem.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module tb_emesh_mem;

   localparam int NCOLS     = 9;
   localparam int MAX_LINES = 64;

   // Columns of one test data line
   localparam int C_PORT     = 0;
   localparam int C_WRITE    = 1;
   localparam int C_DM       = 2;
   localparam int C_CM       = 3;
   localparam int C_DST      = 4;
   localparam int C_DATA     = 5;
   localparam int C_SRC      = 6;
   localparam int C_EXP_DATA = 7;
   localparam int C_EXP_SRC  = 8;

   logic                 clk;
   logic                 nreset;
   logic                 access_in_0;
   logic [`EMESH_PW-1:0] packet_in_0;
   logic                 wait_out_0;
   logic                 access_out_0;
   logic [`EMESH_PW-1:0] packet_out_0;
   logic                 wait_in_0;
   logic                 access_in_1;
   logic [`EMESH_PW-1:0] packet_in_1;
   logic                 wait_out_1;
   logic                 access_out_1;
   logic [`EMESH_PW-1:0] packet_out_1;
   logic                 wait_in_1;

   // Per-port views, bit n is port n
   logic [1:0]           acc_in_v;
   logic [1:0]           wait_out_v;
   logic [1:0]           acc_out_v;
   logic [1:0]           wait_in_v;
   logic [`EMESH_PW-1:0] pkt_out_v [2];

   logic [31:0] td [0:NCOLS*MAX_LINES-1];
   int          num_lines     = 0;
   int          timeout_limit = 0;
   int          cycles        = 0;
   int          value_errors  = 0;
   int          other_errors  = 0;
   int          seed          = 32'hc461;
   int          last_served   = 1;
   logic        after_reset   = 1'b1;
   int          exp_q [2][$];
   int          reads_issued [2];
   int          replies_seen [2];

   assign acc_in_v     = {access_in_1, access_in_0};
   assign wait_out_v   = {wait_out_1, wait_out_0};
   assign acc_out_v    = {access_out_1, access_out_0};
   assign wait_in_v    = {wait_in_1, wait_in_0};
   assign pkt_out_v[0] = packet_out_0;
   assign pkt_out_v[1] = packet_out_1;

   tb_clkgen clkgen_i (
      .clk    (clk),
      .nreset (nreset)
   );

   emesh_mem_top dut_i (
      .clk          (clk),
      .nreset       (nreset),
      .access_in_0  (access_in_0),
      .packet_in_0  (packet_in_0),
      .wait_out_0   (wait_out_0),
      .access_out_0 (access_out_0),
      .packet_out_0 (packet_out_0),
      .wait_in_0    (wait_in_0),
      .access_in_1  (access_in_1),
      .packet_in_1  (packet_in_1),
      .wait_out_1   (wait_out_1),
      .access_out_1 (access_out_1),
      .packet_out_1 (packet_out_1),
      .wait_in_1    (wait_in_1)
   );

   function automatic logic [31:0] field(input int line, input int col);
      return td[NCOLS*line + col];
   endfunction

   function automatic logic port_of(input int line);
      logic [31:0] v;
      v = field(line, C_PORT);
      return v[0];
   endfunction

   function automatic logic [`EMESH_PW-1:0] make_packet(input int line);
      logic [31:0] wr;
      logic [31:0] dm;
      logic [31:0] cm;
      wr = field(line, C_WRITE);
      dm = field(line, C_DM);
      cm = field(line, C_CM);
      return {field(line, C_SRC), field(line, C_DATA), field(line, C_DST),
              cm[4:0], dm[1:0], wr[0]};
   endfunction

   function automatic logic [`EMESH_MAW-1:0] word_addr(input int line);
      logic [31:0] dst;
      dst = field(line, C_DST);
      return dst[`EMESH_MAW+2:3];
   endfunction

   // Two lines may go out together if their order cannot change the memory
   function automatic logic can_pair(input int a, input int b);
      logic both_reads;
      both_reads = (field(a, C_WRITE) == 32'd0) && (field(b, C_WRITE) == 32'd0);
      return (port_of(a) != port_of(b)) && (both_reads || word_addr(a) != word_addr(b));
   endfunction

   task automatic check_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      if (actual !== expected)
      begin
         $display("ERROR: %s actual 0x%0h expected 0x%0h", name, actual, expected);
         value_errors++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("Failure at %0t ns: %s", $time, what);
      other_errors++;
   endtask

   task automatic report_and_finish();
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic load_testdata();
      for (int k = 0; k < NCOLS*MAX_LINES; k++)
         td[k] = 32'hf000_0000 | k;
      $readmemh("dv/emesh_testdata.txt", td);
      // A valid line starts with port 0 or 1
      while (num_lines < MAX_LINES && td[NCOLS*num_lines] <= 32'd1)
         num_lines++;
      if (num_lines == 0)
         report_failure("no request lines found in the test data file");
      timeout_limit = 40 * num_lines + 200;
   endtask

   task automatic drive_port(input int line, input logic on);
      if (port_of(line))
      begin
         access_in_1 <= on;
         packet_in_1 <= make_packet(line);
      end
      else
      begin
         access_in_0 <= on;
         packet_in_0 <= make_packet(line);
      end
   endtask

   task automatic accept_line(input logic p, input int line);
      last_served = p ? 1 : 0;
      if (field(line, C_WRITE) == 32'd0)
      begin
         exp_q[p].push_back(line);
         reads_issued[p]++;
      end
   endtask

   // Present one line, or two on different ports, until each is taken
   task automatic issue(input int a, input int b);
      int         lines [2];
      logic [1:0] pending;
      logic [1:0] taken;
      lines[0] = 0;
      lines[1] = 0;
      pending  = 2'b00;
      @(posedge clk);
      lines[port_of(a)]   = a;
      pending[port_of(a)] = 1'b1;
      drive_port(a, 1'b1);
      if (b >= 0)
      begin
         lines[port_of(b)]   = b;
         pending[port_of(b)] = 1'b1;
         drive_port(b, 1'b1);
      end
      while (pending != 2'b00)
      begin
         @(negedge clk);
         // First request after reset meets an idle endpoint, port 0 first
         if (after_reset)
         begin
            if (pending[0])
               check_value("wait_out_0", 128'(wait_out_0), 128'(1'b0));
            else
               check_value("wait_out_1", 128'(wait_out_1), 128'(1'b0));
            after_reset = 1'b0;
         end
         taken = pending & acc_in_v & ~wait_out_v;
         if (taken == 2'b11)
            report_failure("both ports were granted in the same cycle");
         else if (taken != 2'b00 && pending == 2'b11)
            check_value("grant port", 128'(taken[1]), 128'(last_served == 0));
         if (taken[0])
            accept_line(1'b0, lines[0]);
         if (taken[1])
            accept_line(1'b1, lines[1]);
         @(posedge clk);
         if (taken[0])
            drive_port(lines[0], 1'b0);
         if (taken[1])
            drive_port(lines[1], 1'b0);
         pending = pending & ~taken;
      end
   endtask

   task automatic check_reply(input logic p, input int line, input logic [`EMESH_PW-1:0] pkt);
      string       n;
      logic [31:0] dm;
      logic [31:0] cm;
      n  = $sformatf("packet_out_%0d", p);
      dm = field(line, C_DM);
      cm = field(line, C_CM);
      check_value({n, ".write"}, 128'(pkt[0]), 128'(1'b1));
      check_value({n, ".datamode"}, 128'(pkt[2:1]), 128'(dm[1:0]));
      check_value({n, ".ctrlmode"}, 128'(pkt[7:3]), 128'(cm[4:0]));
      check_value({n, ".dstaddr"}, 128'(pkt[39:8]), 128'(field(line, C_SRC)));
      check_value({n, ".data"}, 128'(pkt[71:40]), 128'(field(line, C_EXP_DATA)));
      check_value({n, ".srcaddr"}, 128'(pkt[103:72]), 128'(field(line, C_EXP_SRC)));
   endtask

   // Replies are taken at the edge after a low wait_in
   task automatic watch_responses(input logic p);
      logic                 held;
      logic [`EMESH_PW-1:0] held_pkt;
      int                   line;
      held     = 1'b0;
      held_pkt = '0;
      forever
      begin
         @(negedge clk);
         if (held && !acc_out_v[p])
            report_failure($sformatf("reply on port %0d dropped while held", p));
         else if (held)
            check_value($sformatf("packet_out_%0d", p), 128'(pkt_out_v[p]), 128'(held_pkt));
         held     = acc_out_v[p] && wait_in_v[p];
         held_pkt = pkt_out_v[p];
         if (acc_out_v[p] && !wait_in_v[p])
         begin
            if (exp_q[p].size() == 0)
               report_failure($sformatf("reply on port %0d without a pending read", p));
            else
            begin
               line = exp_q[p].pop_front();
               check_reply(p, line, pkt_out_v[p]);
            end
            replies_seen[p]++;
         end
      end
   endtask

   initial
   begin
      wait_in_0 <= 1'b0;
      wait_in_1 <= 1'b0;
      forever
      begin
         @(posedge clk);
         if (nreset)
         begin
            int r;
            r = $random(seed);
            wait_in_0 <= r[0];
            wait_in_1 <= r[8];
         end
      end
   end

   initial
   begin
      forever
      begin
         @(posedge clk);
         cycles++;
         if (timeout_limit > 0 && cycles >= timeout_limit)
         begin
            report_failure($sformatf("run did not complete within %0d cycles", cycles));
            report_and_finish();
         end
      end
   end

   initial watch_responses(1'b0);
   initial watch_responses(1'b1);

   initial
   begin
      int i;
      access_in_0 <= 1'b0;
      access_in_1 <= 1'b0;
      packet_in_0 <= '0;
      packet_in_1 <= '0;
      load_testdata();
      @(posedge nreset);
      @(negedge clk);
      check_value("{access_out_1, access_out_0}", 128'(acc_out_v), 128'(2'b00));
      i = 0;
      while (i < num_lines)
      begin
         if (i + 1 < num_lines && can_pair(i, i + 1))
         begin
            issue(i, i + 1);
            i = i + 2;
         end
         else
         begin
            issue(i, -1);
            i = i + 1;
         end
      end
      while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
         @(negedge clk);
      // Quiet window to catch a duplicated reply
      repeat (20) @(negedge clk);
      check_value("reply count port 0", 128'(replies_seen[0]), 128'(reads_issued[0]));
      check_value("reply count port 1", 128'(replies_seen[1]), 128'(reads_issued[1]));
      report_and_finish();
   end

endmodule

//--- emesh_mem_top.f
+incdir+include
source/emesh_pkg.sv
source/emesh_wrlane.sv
source/emesh_rdalign.sv
source/mem_sp.sv
source/emesh_arbiter.sv
source/emesh_mem.sv
source/emesh_mem_top.sv
dv/tb_clkgen.sv
dv/tb_emesh_mem.sv

//--- include/emesh_params.svh
`ifndef EMESH_PARAMS_SVH
`define EMESH_PARAMS_SVH

// Mesh address and data width
`define EMESH_AW 32

// Full packet, two addresses plus data plus 8 control bits
`define EMESH_PW 104

// Memory size in 64-bit words
`define EMESH_DEPTH 1024

// Word address bits, log2 of the depth
`define EMESH_MAW 10

`endif

//--- source/emesh_arbiter.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_arbiter (
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 access_in_0,
   input  logic                 access_in_1,
   input  logic [`EMESH_PW-1:0] packet_in_0,
   input  logic [`EMESH_PW-1:0] packet_in_1,
   output logic                 wait_out_0,
   output logic                 wait_out_1,
   output logic                 access_out_0,
   output logic                 access_out_1,
   output logic [`EMESH_PW-1:0] packet_out_0,
   output logic [`EMESH_PW-1:0] packet_out_1,
   input  logic                 wait_in_0,
   input  logic                 wait_in_1,
   output logic                 mem_access,
   output logic [`EMESH_PW-1:0] mem_packet,
   input  logic                 mem_wait,
   input  logic                 rsp_access,
   input  logic [`EMESH_PW-1:0] rsp_packet,
   output logic                 rsp_wait
);
   import emesh_pkg::*;

   logic          last;
   logic          sel;
   logic          accept;
   logic          pend_tag;
   logic          rsp_tag;
   emesh_fields_t req_fields;

   // Port 1 wins alone, or on a tie when port 0 was served last
   assign sel = access_in_1 & (~access_in_0 | ~last);

   assign mem_access = access_in_0 | access_in_1;
   assign mem_packet = sel ? packet_in_1 : packet_in_0;
   assign accept     = mem_access & ~mem_wait;
   assign req_fields = emesh_unpack(mem_packet);

   // Loser or stalled port is held off
   assign wait_out_0 = access_in_0 & (sel | mem_wait);
   assign wait_out_1 = access_in_1 & (~sel | mem_wait);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         last <= 1'b1;
      else if (accept)
         last <= sel;
   end

   // Tag follows the read through the two endpoint stages
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pend_tag <= 1'b0;
         rsp_tag  <= 1'b0;
      end
      else if (!mem_wait)
      begin
         rsp_tag <= pend_tag;
         if (accept && !req_fields.write)
            pend_tag <= sel;
      end
   end

   // Response steering
   assign access_out_0 = rsp_access & ~rsp_tag;
   assign access_out_1 = rsp_access & rsp_tag;
   assign packet_out_0 = rsp_tag ? '0 : rsp_packet;
   assign packet_out_1 = rsp_tag ? rsp_packet : '0;
   assign rsp_wait     = rsp_tag ? wait_in_1 : wait_in_0;

endmodule

//--- source/emesh_mem.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_mem (
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 access_in,
   input  logic [`EMESH_PW-1:0] packet_in,
   output logic                 wait_out,
   output logic                 access_out,
   output logic [`EMESH_PW-1:0] packet_out,
   input  logic                 wait_in
);
   import emesh_pkg::*;

   emesh_fields_t         req;
   emesh_fields_t         rsp;
   logic [`EMESH_MAW-1:0] addr;
   logic [63:0]           wdata;
   logic [7:0]            wmask;
   logic [63:0]           rdata;
   logic                  en;
   logic                  mem_rd;
   logic                  advance;
   logic [`EMESH_AW-1:0]  rd_data;

   // Read context, one stage behind the request
   logic                  rd_valid;
   datamode_t             rd_datamode;
   ctrlmode_t             rd_ctrlmode;
   logic [2:0]            rd_addr_lo;
   logic [`EMESH_AW-1:0]  rd_dstaddr;

   assign req     = emesh_unpack(packet_in);
   assign addr    = req.dstaddr[`EMESH_MAW+2:3];
   assign advance = ~(access_out & wait_in);
   assign wait_out = ~advance;
   assign en      = access_in & ~wait_out;
   assign mem_rd  = en & ~req.write;

   emesh_wrlane wrlane_i (
      .datamode (req.datamode),
      .addr_lo  (req.dstaddr[2:0]),
      .data     (req.data),
      .srcaddr  (req.srcaddr),
      .wdata    (wdata),
      .wmask    (wmask)
   );

   mem_sp mem_i (
      .clk   (clk),
      .en    (en),
      .we    (req.write),
      .wmask (wmask),
      .addr  (addr),
      .wdata (wdata),
      .rdata (rdata)
   );

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_valid   <= 1'b0;
         access_out <= 1'b0;
      end
      else if (advance)
      begin
         rd_valid   <= mem_rd;
         access_out <= rd_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_rd)
      begin
         rd_datamode <= req.datamode;
         rd_ctrlmode <= req.ctrlmode;
         rd_addr_lo  <= req.dstaddr[2:0];
         rd_dstaddr  <= req.srcaddr;
      end
   end

   emesh_rdalign rdalign_i (
      .datamode (rd_datamode),
      .addr_lo  (rd_addr_lo),
      .rdata    (rdata),
      .data     (rd_data)
   );

   // Reply goes back to the requester's srcaddr
   always_comb
   begin
      rsp.write    = 1'b1;
      rsp.datamode = rd_datamode;
      rsp.ctrlmode = rd_ctrlmode;
      rsp.dstaddr  = rd_dstaddr;
      rsp.data     = rd_data;
      rsp.srcaddr  = (rd_datamode == DM_DOUBLE) ? rdata[63:32] : '0;
   end

   // Capture register, frozen while the receiver pushes back
   always_ff @(posedge clk)
   begin
      if (advance && rd_valid)
         packet_out <= emesh_pack(rsp);
   end

endmodule

//--- source/emesh_mem_top.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_mem_top (
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 access_in_0,
   input  logic [`EMESH_PW-1:0] packet_in_0,
   output logic                 wait_out_0,
   output logic                 access_out_0,
   output logic [`EMESH_PW-1:0] packet_out_0,
   input  logic                 wait_in_0,
   input  logic                 access_in_1,
   input  logic [`EMESH_PW-1:0] packet_in_1,
   output logic                 wait_out_1,
   output logic                 access_out_1,
   output logic [`EMESH_PW-1:0] packet_out_1,
   input  logic                 wait_in_1
);

   // Arbiter to endpoint
   logic                 mem_access;
   logic [`EMESH_PW-1:0] mem_packet;
   logic                 mem_wait;

   // Endpoint back to arbiter
   logic                 rsp_access;
   logic [`EMESH_PW-1:0] rsp_packet;
   logic                 rsp_wait;

   emesh_arbiter arbiter_i (
      .clk          (clk),
      .nreset       (nreset),
      .access_in_0  (access_in_0),
      .access_in_1  (access_in_1),
      .packet_in_0  (packet_in_0),
      .packet_in_1  (packet_in_1),
      .wait_out_0   (wait_out_0),
      .wait_out_1   (wait_out_1),
      .access_out_0 (access_out_0),
      .access_out_1 (access_out_1),
      .packet_out_0 (packet_out_0),
      .packet_out_1 (packet_out_1),
      .wait_in_0    (wait_in_0),
      .wait_in_1    (wait_in_1),
      .mem_access   (mem_access),
      .mem_packet   (mem_packet),
      .mem_wait     (mem_wait),
      .rsp_access   (rsp_access),
      .rsp_packet   (rsp_packet),
      .rsp_wait     (rsp_wait)
   );

   emesh_mem mem_i (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (mem_access),
      .packet_in  (mem_packet),
      .wait_out   (mem_wait),
      .access_out (rsp_access),
      .packet_out (rsp_packet),
      .wait_in    (rsp_wait)
   );

endmodule

//--- source/emesh_pkg.sv
`include "emesh_params.svh"

package emesh_pkg;

   // Transfer size of a mesh transaction
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_SHORT  = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_t;

   // Only the normal mode is named, other codes pass through as is
   typedef enum logic [4:0] {
      CM_NORMAL = 5'b00000
   } ctrlmode_t;

   // Packet fields, msb first
   typedef struct packed {
      logic [`EMESH_AW-1:0] srcaddr;
      logic [`EMESH_AW-1:0] data;
      logic [`EMESH_AW-1:0] dstaddr;
      ctrlmode_t            ctrlmode;
      datamode_t            datamode;
      logic                 write;
   } emesh_fields_t;

   function automatic logic [`EMESH_PW-1:0] emesh_pack(input emesh_fields_t f);
      logic [`EMESH_PW-1:0] packet;
      packet = {f.srcaddr, f.data, f.dstaddr, f.ctrlmode, f.datamode, f.write};
      return packet;
   endfunction

   function automatic emesh_fields_t emesh_unpack(input logic [`EMESH_PW-1:0] packet);
      emesh_fields_t f;
      f.write    = packet[0];
      f.datamode = datamode_t'(packet[2:1]);
      f.ctrlmode = ctrlmode_t'(packet[7:3]);
      f.dstaddr  = packet[8 +: `EMESH_AW];
      f.data     = packet[8+`EMESH_AW +: `EMESH_AW];
      f.srcaddr  = packet[8+2*`EMESH_AW +: `EMESH_AW];
      return f;
   endfunction

endpackage

//--- source/emesh_rdalign.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_rdalign (
   input  emesh_pkg::datamode_t  datamode,
   input  logic [2:0]            addr_lo,
   input  logic [63:0]           rdata,
   output logic [`EMESH_AW-1:0]  data
);
   import emesh_pkg::*;

   logic [5:0] byte_pos;
   logic [5:0] short_pos;
   logic [5:0] word_pos;

   // Bit offsets of the addressed lane
   assign byte_pos  = {addr_lo, 3'b000};
   assign short_pos = {addr_lo[2:1], 4'b0000};
   assign word_pos  = {addr_lo[2], 5'b00000};

   // Move the lane to the bottom, upper bits zero
   always_comb
   begin
      data = '0;
      unique case (datamode)
         DM_BYTE:
         begin
            data[7:0] = rdata[byte_pos +: 8];
         end
         DM_SHORT:
         begin
            data[15:0] = rdata[short_pos +: 16];
         end
         DM_WORD:
         begin
            data = rdata[word_pos +: 32];
         end
         DM_DOUBLE:
         begin
            data = rdata[31:0];
         end
      endcase
   end

endmodule

//--- source/emesh_wrlane.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_wrlane (
   input  emesh_pkg::datamode_t  datamode,
   input  logic [2:0]            addr_lo,
   input  logic [`EMESH_AW-1:0]  data,
   input  logic [`EMESH_AW-1:0]  srcaddr,
   output logic [63:0]           wdata,
   output logic [7:0]            wmask
);
   import emesh_pkg::*;

   logic [31:0] word;

   // Spread small writes over every lane of the word
   always_comb
   begin
      unique case (datamode)
         DM_BYTE:   word = {4{data[7:0]}};
         DM_SHORT:  word = {2{data[15:0]}};
         DM_WORD:   word = data;
         DM_DOUBLE: word = data;
      endcase
   end

   // Double carries its upper half in srcaddr
   assign wdata = (datamode == DM_DOUBLE) ? {srcaddr, data} : {word, word};

   always_comb
   begin
      wmask = 8'h00;
      unique case (datamode)
         DM_BYTE:
         begin
            wmask = 8'b0000_0001 << addr_lo;
         end
         DM_SHORT:
         begin
            wmask = 8'b0000_0011 << {addr_lo[2:1], 1'b0};
         end
         DM_WORD:
         begin
            wmask = 8'b0000_1111 << {addr_lo[2], 2'b00};
         end
         DM_DOUBLE:
         begin
            wmask = 8'hff;
         end
      endcase
   end

endmodule

//--- source/mem_sp.sv
`timescale 1ns/1ps
`include "emesh_params.svh"

module mem_sp (
   input  logic                  clk,
   input  logic                  en,
   input  logic                  we,
   input  logic [7:0]            wmask,
   input  logic [`EMESH_MAW-1:0] addr,
   input  logic [63:0]           wdata,
   output logic [63:0]           rdata
);

   logic [63:0] mem [0:`EMESH_DEPTH-1];

   // Byte-masked write, registered read
   always_ff @(posedge clk)
   begin
      if (en)
      begin
         if (we)
         begin
            for (int i = 0; i < 8; i++)
            begin
               if (wmask[i])
                  mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
         else
         begin
            rdata <= mem[addr];
         end
      end
   end

   // Read port keeps its last value through writes

endmodule
